// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := saturnGlueTb
FILELIST  := files.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) dv/saturnGlueRef.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== dv/saturnGlueRef.svh ====
`ifndef SATURN_GLUE_REF_SVH
`define SATURN_GLUE_REF_SVH

// Any of the four memory regions on the CPU bus
function automatic logic memSelected(saturnPkg::cpuReqT req, saturnPkg::memSelT sel);
	return !req.cs3N || !sel.dramCeN || !sel.romCeN || !sel.sramCeN;
endfunction

// Memory first, then SMPC, SCU as the fallback
function automatic saturnPkg::cpuWordT cpuReadValue(saturnPkg::cpuReqT req,
		saturnPkg::memSelT sel, saturnPkg::cpuWordT mem, saturnPkg::cpuWordT scu,
		logic [7:0] smpc);
	if (memSelected(req, sel))
		return mem;
	if (!sel.smpcCeN)
		return {smpc, smpc, smpc, smpc};
	return scu;
endfunction

function automatic logic cpuWaitValue(saturnPkg::cpuReqT req, saturnPkg::memSelT sel,
		logic memWaitN, logic scuWaitN);
	if (!scuWaitN)
		return 1'b0;
	return memSelected(req, sel) ? memWaitN : 1'b1;
endfunction

function automatic saturnPkg::memPortT memPortValue(saturnPkg::cpuReqT req,
		saturnPkg::memSelT sel);
	saturnPkg::memPortT p;
	p = '{addr: req.addr, wdata: req.wdata, dqmN: req.dqmN, rdN: req.rdN,
		romCsN: sel.romCeN, sramCsN: sel.sramCeN, ramlCsN: sel.dramCeN, ramhCsN: req.cs3N};
	return p;
endfunction

function automatic saturnPkg::subWordT aBusValue(logic cs0N, logic cs1N, logic cs2N,
		saturnPkg::subWordT cart, saturnPkg::subWordT cd);
	if (!cs0N || !cs1N)
		return cart;
	if (!cs2N)
		return cd;
	return saturnPkg::ABusIdle;
endfunction

function automatic saturnPkg::subWordT bBusValue(logic cs1N, logic cs2N, logic cssN,
		saturnPkg::subWordT vdp1, saturnPkg::subWordT vdp2, saturnPkg::subWordT scsp);
	if (!cs1N)
		return vdp1;
	if (!cs2N)
		return vdp2;
	if (!cssN)
		return scsp;
	return saturnPkg::BBusIdle;
endfunction

function automatic saturnPkg::cdRamPortT cdRamPortValue(saturnPkg::cdCpuReqT req,
		saturnPkg::subWordT ygr, logic dack0N, logic dack1N);
	saturnPkg::cdRamPortT p;
	p.addr  = req.addr[saturnPkg::CdRamAddrW-1:0];
	p.wdata = (!dack0N || !dack1N) ? ygr : req.wdata;   // DMA data wins
	p.we    = {!req.wrhN, !req.wrlN};
	p.rd    = !req.rdN;
	p.cs    = !req.cs1N;
	return p;
endfunction

function automatic saturnPkg::subWordT shReadValue(saturnPkg::cdCpuReqT req,
		saturnPkg::subWordT ramQ, saturnPkg::subWordT ygr);
	return req.cs1N ? ygr : ramQ;
endfunction

function automatic logic [saturnPkg::WaitCntW-1:0] waitCntAfter(
		logic [saturnPkg::WaitCntW-1:0] cnt, logic ce, saturnPkg::cpuReqT req);
	if (!ce)
		return cnt;
	if (!req.rdN || req.dqmN != 4'hF)
		return '0;
	return cnt + 1'b1;   // Wraps at the counter width
endfunction

function automatic logic hookAfter(logic hook, logic ce, saturnPkg::cpuReqT req);
	return hook || (ce && req.addr == saturnPkg::HookAddr && !req.rdN && !req.cs3N);
endfunction

function automatic logic phaseAfter(logic phase, logic cdCe);
	return cdCe ? !phase : phase;
endfunction

`endif

// ==== dv/saturnGlueTb.sv ====
`timescale 1ns/1ps

module saturnGlueTb;

	logic                 CLK;
	logic                 RST_N;
	logic                 sysCeR;
	logic                 cdCe;
	saturnPkg::cpuReqT    cpuReq;
	saturnPkg::memSelT    memSel;
	saturnPkg::cpuWordT   memData;
	saturnPkg::cpuWordT   scuData;
	logic [7:0]           smpcData;
	logic                 memWaitN;
	logic                 scuWaitN;
	saturnPkg::memPortT   memPort;
	saturnPkg::cpuWordT   cpuRdata;
	logic                 cpuWaitN;
	logic                 aCs0N, aCs1N, aCs2N, cartAwaitN, cdAwaitN, aWaitN;
	saturnPkg::subWordT   cartData, cdData, aRdata;
	logic                 bCs1N, bCs2N, bCssN;
	saturnPkg::subWordT   vdp1Data, vdp2Data, scspData, bRdata;
	saturnPkg::cdCpuReqT  cdCpuReq;
	saturnPkg::subWordT   ygrData, cdRamQ, shRdata;
	logic                 dack0N, dack1N, cdRamRdy, shWaitN, shCeR, shCeF;
	saturnPkg::cdRamPortT cdRamPort;
	logic [saturnPkg::WaitCntW-1:0] waitCnt;
	logic                 hook;

	// Model copies of the DUT state
	logic [saturnPkg::WaitCntW-1:0] modelCnt;
	logic                 modelHook;
	logic                 modelPhase;
	int                   errCount;
	int                   testsRun;
	int                   testsFailed;

	`include "saturnGlueRef.svh"

	saturnGlue i_dut (.*);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	task automatic checkHex(input string name, input string got, input string exp);
		if (got != exp) begin
			errCount++;
			$display("Error: %s expected 0x%s got 0x%s at %0t", name, exp, got, $time);
		end
	endtask

	task automatic driveInputs(input logic cdActive, input logic idleOnly);
		logic [31:0] rnd;
		logic [31:0] rnd2;
		rnd  = $urandom();
		rnd2 = $urandom();
		cpuReq.addr = rnd2[24:0];
		if (cpuReq.addr == saturnPkg::HookAddr)
			cpuReq.addr[0] = 1'b1;   // Hook only from the directed read
		cpuReq.wdata   = $urandom();
		cpuReq.dqmN    = (rnd[2:0] == 3'd0 && !idleOnly) ? rnd[6:3] : 4'hF;
		cpuReq.rdN     = idleOnly | rnd[7] | rnd[8];
		cpuReq.cs3N    = rnd[9];
		memSel.dramCeN = rnd[11:10] != 2'd1;   // At most one region low
		memSel.romCeN  = rnd[11:10] != 2'd2;
		memSel.sramCeN = rnd[11:10] != 2'd3;
		memSel.smpcCeN = rnd[12];
		memWaitN       = rnd[13];
		scuWaitN       = rnd[14] | rnd[15];
		smpcData       = rnd[23:16];
		aCs0N          = rnd[24] | rnd[25];
		aCs1N          = rnd[26] | rnd[27];
		aCs2N          = rnd[28] | rnd[29];
		cartAwaitN     = rnd[30];
		cdAwaitN       = rnd[31];
		bCs1N          = rnd2[25] | rnd2[26];
		bCs2N          = rnd2[27] | rnd2[28];
		bCssN          = rnd2[29] | rnd2[30];
		rnd = $urandom();
		cdCpuReq.addr = rnd[20:0];
		cdCpuReq.wrlN = rnd[21];
		cdCpuReq.wrhN = rnd[22];
		cdCpuReq.rdN  = rnd[23];
		cdCpuReq.cs1N = rnd[24];
		dack0N        = rnd[25] | rnd[26];
		dack1N        = rnd[27] | rnd[28];
		cdRamRdy      = rnd[29];
		cdCe          = cdActive & rnd[30];
		sysCeR        = idleOnly | rnd[31] | rnd2[31];
		memData  = $urandom();
		scuData  = $urandom();
		rnd      = $urandom();
		cartData = rnd[15:0];
		cdData   = rnd[31:16];
		rnd      = $urandom();
		vdp1Data = rnd[15:0];
		vdp2Data = rnd[31:16];
		rnd      = $urandom();
		scspData = rnd[15:0];
		ygrData  = rnd[31:16];
		rnd      = $urandom();
		cdRamQ   = rnd[15:0];
		cdCpuReq.wdata = rnd[31:16];
	endtask

	initial begin : compareProc
		saturnPkg::cpuReqT capReq;
		logic capSysCe;
		logic capCdCe;
		logic capRst;
		forever begin
			@(negedge CLK);
			#40;   // Settled, ahead of the rising edge
			checkHex("cpuRdata", $sformatf("%h", cpuRdata),
				$sformatf("%h", cpuReadValue(cpuReq, memSel, memData, scuData, smpcData)));
			checkHex("cpuWaitN", $sformatf("%h", cpuWaitN),
				$sformatf("%h", cpuWaitValue(cpuReq, memSel, memWaitN, scuWaitN)));
			checkHex("memPort", $sformatf("%h", memPort),
				$sformatf("%h", memPortValue(cpuReq, memSel)));
			checkHex("aRdata", $sformatf("%h", aRdata),
				$sformatf("%h", aBusValue(aCs0N, aCs1N, aCs2N, cartData, cdData)));
			checkHex("aWaitN", $sformatf("%h", aWaitN), $sformatf("%h", cartAwaitN & cdAwaitN));
			checkHex("bRdata", $sformatf("%h", bRdata),
				$sformatf("%h", bBusValue(bCs1N, bCs2N, bCssN, vdp1Data, vdp2Data, scspData)));
			checkHex("cdRamPort", $sformatf("%h", cdRamPort),
				$sformatf("%h", cdRamPortValue(cdCpuReq, ygrData, dack0N, dack1N)));
			checkHex("shRdata", $sformatf("%h", shRdata),
				$sformatf("%h", shReadValue(cdCpuReq, cdRamQ, ygrData)));
			checkHex("shWaitN", $sformatf("%h", shWaitN), $sformatf("%h", cdRamRdy));
			checkHex("shCeR", $sformatf("%h", shCeR), $sformatf("%h", modelPhase & cdCe));
			checkHex("shCeF", $sformatf("%h", shCeF), $sformatf("%h", ~modelPhase & cdCe));
			capReq   = cpuReq;
			capSysCe = sysCeR;
			capCdCe  = cdCe;
			capRst   = RST_N;
			@(posedge CLK);
			#1;
			if (!capRst) begin
				modelCnt   = '0;
				modelHook  = 1'b0;
				modelPhase = 1'b0;
			end else begin
				modelCnt   = waitCntAfter(modelCnt, capSysCe, capReq);
				modelHook  = hookAfter(modelHook, capSysCe, capReq);
				modelPhase = phaseAfter(modelPhase, capCdCe);
			end
			checkHex("waitCnt", $sformatf("%h", waitCnt), $sformatf("%h", modelCnt));
			checkHex("hook", $sformatf("%h", hook), $sformatf("%h", modelHook));
		end
	end

	task automatic runCycles(input int cycles, input logic cdActive, input logic idleOnly);
		for (int i = 0; i < cycles; i++) begin
			@(negedge CLK);
			driveInputs(cdActive, idleOnly);
		end
		@(posedge CLK);
		#2;   // Last vector fully compared
	endtask

	task automatic reportTest(input string name, input int errBefore);
		testsRun++;
		if (errCount == errBefore) begin
			$display("Test %s: ok", name);
		end else begin
			testsFailed++;
			$display("Test %s: FAILED with %0d errors", name, errCount - errBefore);
		end
	endtask

	task automatic monitorTest();
		int errBefore;
		int cycles;
		errBefore = errCount;
		runCycles(300, 1'b0, 1'b1);   // Idle run long enough to wrap
		runCycles(300, 1'b0, 1'b0);
		// Boot address without a read, without CS3, and without the system enable
		for (int i = 0; i < 3; i++) begin
			@(negedge CLK);
			driveInputs(1'b0, 1'b1);
			cpuReq.addr = saturnPkg::HookAddr;
			cpuReq.rdN  = (i == 0);
			cpuReq.cs3N = (i == 1);
			sysCeR      = (i != 2);
		end
		@(posedge CLK);
		#2;
		if (hook !== 1'b0) begin
			errCount++;
			$display("hook was set before the boot address was read");
		end
		@(negedge CLK);
		driveInputs(1'b0, 1'b1);
		cpuReq.addr = saturnPkg::HookAddr;
		cpuReq.rdN  = 1'b0;
		cpuReq.cs3N = 1'b0;
		cycles = 0;
		while (hook !== 1'b1 && cycles < 8) begin
			@(posedge CLK);
			#1;
			cycles++;
		end
		if (hook !== 1'b1) begin
			errCount++;
			$display("hook did not rise within 8 cycles of the boot read");
		end else if (cycles != 1) begin
			errCount++;
			$display("hook rose %0d cycles after the boot read instead of one", cycles);
		end
		runCycles(50, 1'b0, 1'b0);   // Must stay set
		reportTest("access monitor", errBefore);
	endtask

	initial begin
		int errBefore;
		void'($urandom(32'ha075));
		errCount    = 0;
		testsRun    = 0;
		testsFailed = 0;
		modelCnt    = '0;
		modelHook   = 1'b0;
		modelPhase  = 1'b0;
		RST_N       = 1'b0;
		driveInputs(1'b0, 1'b1);
		repeat (10) @(posedge CLK);
		@(negedge CLK);
		RST_N = 1'b1;
		errBefore = errCount;
		runCycles(400, 1'b0, 1'b0);
		reportTest("CPU read priority and wait", errBefore);
		errBefore = errCount;
		runCycles(300, 1'b0, 1'b0);
		reportTest("memory port mapping", errBefore);
		errBefore = errCount;
		runCycles(300, 1'b0, 1'b0);
		reportTest("A-bus and B-bus selects", errBefore);
		// cdCe held low until now, so the first pulse must be shCeF
		errBefore = errCount;
		runCycles(400, 1'b1, 1'b0);
		reportTest("CD port and clock enables", errBefore);
		monitorTest();
		$display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
		if (errCount == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+dv
src/saturnPkg.sv
src/busReadMux.sv
src/cpuBusCtrl.sv
src/cdSubsystemPort.sv
src/accessMonitor.sv
src/saturnGlue.sv
dv/saturnGlueTb.sv

// ==== src/accessMonitor.sv ====
`timescale 1ns/1ps

module accessMonitor (
	input  logic                            CLK,
	input  logic                            RST_N,
	input  logic                            sysCeR,
	input  saturnPkg::cpuReqT               cpuReq,
	output logic [saturnPkg::WaitCntW-1:0]  waitCnt,
	output logic                            hook
);

	logic access;
	logic hookHit;

	// Read or any byte write strobe
	assign access  = !cpuReq.rdN || !(&cpuReq.dqmN);
	assign hookHit = (cpuReq.addr == saturnPkg::HookAddr) && !cpuReq.rdN && !cpuReq.cs3N;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			waitCnt <= '0;
			hook    <= 1'b0;
		end else if (sysCeR) begin
			if (access) begin
				waitCnt <= '0;
			end else begin
				waitCnt <= waitCnt + 1'b1;   // Wraps
			end
			if (hookHit) begin
				hook <= 1'b1;
			end
		end
	end

	// Sticky until reset
	a_hookSticky: assert property (@(posedge CLK) disable iff (!RST_N) hook |=> hook)
		else $error("accessMonitor: hook flag cleared");

endmodule

// ==== src/busReadMux.sv ====
`timescale 1ns/1ps

module busReadMux #(
	parameter type     payloadT = logic [15:0],
	parameter int      N        = 2,
	parameter payloadT Idle     = '0
) (
	input  logic [N-1:0] selN,
	input  payloadT      data [N],
	output payloadT      rdata
);

	// Walk from the top so the lowest active select lands last
	always_comb begin
		rdata = Idle;
		for (int i = N - 1; i >= 0; i--) begin
			if (!selN[i]) begin
				rdata = data[i];
			end
		end
	end

endmodule

// ==== src/cdSubsystemPort.sv ====
`timescale 1ns/1ps

module cdSubsystemPort (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 cdCe,
	input  saturnPkg::cdCpuReqT  cdCpuReq,
	input  saturnPkg::subWordT   ygrData,
	input  saturnPkg::subWordT   cdRamQ,
	input  logic                 dack0N,
	input  logic                 dack1N,
	input  logic                 cdRamRdy,
	output saturnPkg::cdRamPortT cdRamPort,
	output saturnPkg::subWordT   shRdata,
	output logic                 shWaitN,
	output logic                 shCeR,
	output logic                 shCeF
);

	logic dmaAck;
	logic phase;

	assign dmaAck = !dack0N || !dack1N;

	always_comb begin
		cdRamPort.addr  = cdCpuReq.addr[saturnPkg::CdRamAddrW-1:0];
		cdRamPort.wdata = dmaAck ? ygrData : cdCpuReq.wdata;   // DMA from CD block
		cdRamPort.we    = ~{cdCpuReq.wrhN, cdCpuReq.wrlN};
		cdRamPort.rd    = ~cdCpuReq.rdN;
		cdRamPort.cs    = ~cdCpuReq.cs1N;
	end

	// RAM on CS1, everything else from the CD block
	assign shRdata = !cdCpuReq.cs1N ? cdRamQ : ygrData;
	assign shWaitN = cdRamRdy;

	// SH1 runs at half the CD enable rate
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			phase <= 1'b0;
		end else if (cdCe) begin
			phase <= ~phase;
		end
	end

	assign shCeR = phase & cdCe;
	assign shCeF = ~phase & cdCe;

	a_ceExclusive: assert property (@(posedge CLK) disable iff (!RST_N)
		!(shCeR && shCeF))
		else $error("cdSubsystemPort: rising and falling enables together");

endmodule

// ==== src/cpuBusCtrl.sv ====
`timescale 1ns/1ps

module cpuBusCtrl (
	input  saturnPkg::cpuReqT  cpuReq,
	input  saturnPkg::memSelT  memSel,
	input  logic               memWaitN,
	input  logic               scuWaitN,
	output saturnPkg::memPortT memPort,
	output logic [2:0]         cpuSelN,
	output logic               cpuWaitN
);

	logic memAcc;

	// Any of the four memory regions
	assign memAcc = !cpuReq.cs3N || !memSel.dramCeN || !memSel.romCeN || !memSel.sramCeN;

	// Read source selects, lowest entry wins
	assign cpuSelN[0] = ~memAcc;          // Memory data
	assign cpuSelN[1] = memSel.smpcCeN;   // SMPC byte
	assign cpuSelN[2] = 1'b0;             // SCU registers and buses

	// Memory wait only matters while memory is addressed
	assign cpuWaitN = scuWaitN & (memWaitN | ~memAcc);

	always_comb begin
		memPort.addr    = cpuReq.addr;
		memPort.wdata   = cpuReq.wdata;
		memPort.dqmN    = cpuReq.dqmN;
		memPort.rdN     = cpuReq.rdN;
		memPort.romCsN  = memSel.romCeN;
		memPort.sramCsN = memSel.sramCeN;
		memPort.ramlCsN = memSel.dramCeN;   // Low work RAM
		memPort.ramhCsN = cpuReq.cs3N;      // High work RAM on CS3
	end

	// Decoder regions never overlap
	always_comb begin
		assert ($onehot0(~{memSel.romCeN, memSel.sramCeN, memSel.dramCeN}))
			else $error("cpuBusCtrl: more than one memory chip select low");
	end

endmodule

// ==== src/saturnGlue.sv ====
`timescale 1ns/1ps

module saturnGlue (
	input  logic                            CLK,
	input  logic                            RST_N,
	input  logic                            sysCeR,
	input  logic                            cdCe,

	// Main CPU bus
	input  saturnPkg::cpuReqT               cpuReq,
	input  saturnPkg::memSelT               memSel,
	input  saturnPkg::cpuWordT              memData,
	input  saturnPkg::cpuWordT              scuData,
	input  logic [7:0]                      smpcData,
	input  logic                            memWaitN,
	input  logic                            scuWaitN,
	output saturnPkg::memPortT              memPort,
	output saturnPkg::cpuWordT              cpuRdata,
	output logic                            cpuWaitN,

	// A-bus
	input  logic                            aCs0N,
	input  logic                            aCs1N,
	input  logic                            aCs2N,
	input  logic                            cartAwaitN,
	input  logic                            cdAwaitN,
	input  saturnPkg::subWordT              cartData,
	input  saturnPkg::subWordT              cdData,
	output saturnPkg::subWordT              aRdata,
	output logic                            aWaitN,

	// B-bus
	input  logic                            bCs1N,
	input  logic                            bCs2N,
	input  logic                            bCssN,
	input  saturnPkg::subWordT              vdp1Data,
	input  saturnPkg::subWordT              vdp2Data,
	input  saturnPkg::subWordT              scspData,
	output saturnPkg::subWordT              bRdata,

	// CD subsystem
	input  saturnPkg::cdCpuReqT             cdCpuReq,
	input  saturnPkg::subWordT              ygrData,
	input  saturnPkg::subWordT              cdRamQ,
	input  logic                            dack0N,
	input  logic                            dack1N,
	input  logic                            cdRamRdy,
	output saturnPkg::cdRamPortT            cdRamPort,
	output saturnPkg::subWordT              shRdata,
	output logic                            shWaitN,
	output logic                            shCeR,
	output logic                            shCeF,

	// Monitor
	output logic [saturnPkg::WaitCntW-1:0]  waitCnt,
	output logic                            hook
);

	logic [2:0]         cpuSelN;
	saturnPkg::cpuWordT cpuMuxData [3];
	logic [1:0]         aSelN;
	saturnPkg::subWordT aMuxData [2];
	logic [2:0]         bSelN;
	saturnPkg::subWordT bMuxData [3];

	cpuBusCtrl i_cpuBusCtrl (
		.cpuReq   (cpuReq),
		.memSel   (memSel),
		.memWaitN (memWaitN),
		.scuWaitN (scuWaitN),
		.memPort  (memPort),
		.cpuSelN  (cpuSelN),
		.cpuWaitN (cpuWaitN)
	);

	assign cpuMuxData[0] = memData;
	assign cpuMuxData[1] = {4{smpcData}};   // SMPC byte on every lane
	assign cpuMuxData[2] = scuData;

	busReadMux #(.payloadT(saturnPkg::cpuWordT), .N(3), .Idle(saturnPkg::CpuIdle)) i_cpuMux (
		.selN  (cpuSelN),
		.data  (cpuMuxData),
		.rdata (cpuRdata)
	);

	// Cart owns CS0 and CS1, CD block sits on CS2
	assign aSelN       = {aCs2N, aCs0N & aCs1N};
	assign aMuxData[0] = cartData;
	assign aMuxData[1] = cdData;
	assign aWaitN      = cdAwaitN & cartAwaitN;

	busReadMux #(.payloadT(saturnPkg::subWordT), .N(2), .Idle(saturnPkg::ABusIdle)) i_aMux (
		.selN  (aSelN),
		.data  (aMuxData),
		.rdata (aRdata)
	);

	assign bSelN       = {bCssN, bCs2N, bCs1N};
	assign bMuxData[0] = vdp1Data;
	assign bMuxData[1] = vdp2Data;
	assign bMuxData[2] = scspData;

	busReadMux #(.payloadT(saturnPkg::subWordT), .N(3), .Idle(saturnPkg::BBusIdle)) i_bMux (
		.selN  (bSelN),
		.data  (bMuxData),
		.rdata (bRdata)
	);

	cdSubsystemPort i_cdPort (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.cdCe      (cdCe),
		.cdCpuReq  (cdCpuReq),
		.ygrData   (ygrData),
		.cdRamQ    (cdRamQ),
		.dack0N    (dack0N),
		.dack1N    (dack1N),
		.cdRamRdy  (cdRamRdy),
		.cdRamPort (cdRamPort),
		.shRdata   (shRdata),
		.shWaitN   (shWaitN),
		.shCeR     (shCeR),
		.shCeF     (shCeF)
	);

	accessMonitor i_monitor (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.sysCeR  (sysCeR),
		.cpuReq  (cpuReq),
		.waitCnt (waitCnt),
		.hook    (hook)
	);

endmodule

// ==== src/saturnPkg.sv ====
package saturnPkg;

	// Bus widths
	localparam int CpuAddrW   = 25;
	localparam int CpuDataW   = 32;
	localparam int SubDataW   = 16;
	localparam int CdCpuAddrW = 21;   // Sub-CPU word address A[21:1]
	localparam int CdRamAddrW = 18;
	localparam int WaitCntW   = 8;

	typedef logic [CpuDataW-1:0] cpuWordT;
	typedef logic [SubDataW-1:0] subWordT;

	// Boot hook, read through high RAM select
	localparam logic [CpuAddrW-1:0] HookAddr = 25'h00_12B0;

	// Read values when no source is selected
	localparam subWordT ABusIdle = 16'hFFFF;
	localparam subWordT BBusIdle = 16'h0000;
	localparam cpuWordT CpuIdle  = '0;   // SCU entry always selected

	// Master CPU request as seen by SCU and DCC
	typedef struct packed {
		logic [CpuAddrW-1:0] addr;
		cpuWordT             wdata;
		logic [3:0]          dqmN;
		logic                rdN;
		logic                cs3N;
	} cpuReqT;

	// DCC decoder outputs
	typedef struct packed {
		logic dramCeN;
		logic romCeN;
		logic sramCeN;
		logic smpcCeN;
	} memSelT;

	// External memory port
	typedef struct packed {
		logic [CpuAddrW-1:0] addr;
		cpuWordT             wdata;
		logic [3:0]          dqmN;
		logic                rdN;
		logic                romCsN;
		logic                sramCsN;
		logic                ramlCsN;
		logic                ramhCsN;
	} memPortT;

	// SH1 side of the CD block
	typedef struct packed {
		logic [CdCpuAddrW-1:0] addr;
		subWordT               wdata;
		logic                  wrlN;
		logic                  wrhN;
		logic                  rdN;
		logic                  cs1N;
	} cdCpuReqT;

	// CD buffer RAM, active-high strobes
	typedef struct packed {
		logic [CdRamAddrW-1:0] addr;
		subWordT               wdata;
		logic [1:0]            we;   // {high, low} byte
		logic                  rd;
		logic                  cs;
	} cdRamPortT;

endpackage
